//--- pe_row_stim.txt
# per test: name conf(hex) split nin nwt nres, then inputs, weights col0..col3, expected (hex)
# split = inputs written before the weights; expected in address order t*cols+c
d16_unit 4413 6 6 3 16
01 02 03 04 05 06
01 00 00  00 01 00  01 01 01  02 ff 03
0001 0002 0006 0009 0002 0003 0009 000d 0003 0004 000c 0011 0004 0005 000f 0015
d16_stride 8322 5 12 4 12
01 ff 02 fe 03 fd 04 fc 05 fb 06 fa
01 00 00 00  00 01 00 00  02 00 00 fd  7f 81 7f 81
0001 ffff 0008 02fa 0003 fffd 0012 06f2 0005 fffb 001c 0aea
d8_lanes 18212 2 6 4 8
0a 64 14 64 1e 64
01 01 01 01  02 03 00 00  ff ff 00 00  10 00 00 02
c81e 2c14 9cf6 c8a0 c832 2c28 9cec c840
end

//--- pe_row.f
+incdir+.
pe_cfg_pkg.sv
pe_bus_pkg.sv
loop_counter.sv
datapath_ctl.sv
pe_col.sv
pe_feeder.sv
psum_drain.sv
pe_row_top.sv
pe_row_properties.sv
tb_pe_row.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f pe_row.f --top-module tb_pe_row -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only --timing -f pe_row.f --top-module tb_pe_row

clean:
	rm -rf obj_dir sim.log

//--- tb_pe_row.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module tb_pe_row;

    localparam int TIMEOUT = 2000;

    logic                 i_clk;
    logic                 i_rst_n;
    logic                 i_wb_cyc;
    logic                 i_wb_stb;
    logic                 i_wb_we;
    logic [`WB_ADR_W-1:0] i_wb_adr;
    logic [`WB_DAT_W-1:0] i_wb_dat;
    logic                 o_wb_ack;
    logic                 i_rd_cyc;
    logic                 i_rd_stb;
    logic [`WB_ADR_W-1:0] i_rd_adr;
    logic [`PSUM_W-1:0]   o_rd_dat;
    logic                 o_rd_ack;

    int          errors;
    int          fd;
    int          code;
    string       name;
    string       line;
    logic [31:0] conf;
    int          split;
    int          nin;
    int          nwt;
    int          nres;
    logic [7:0]  in_vals [64];
    logic [7:0]  wt_vals [`PE_COLS][16];
    logic [15:0] exp_vals [64];
    logic [15:0] rd_val;

    pe_row_top i_dut (.*);

    always #20 i_clk = ~i_clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 4;
        repeat (n) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    // one classic write, held until ack
    task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
        int k;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b1;
        i_wb_adr = adr;
        i_wb_dat = dat;
        for (k = 0; k < TIMEOUT; k++) begin
            @(posedge i_clk);
            #1;
            if (o_wb_ack) break;
        end
        if (k == TIMEOUT) stop_run($sformatf("write to address %h never acknowledged", adr));
        // cycle ends at the edge that samples the ack
        @(posedge i_clk);
        #1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        idle_gap();
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [15:0] dat);
        int k;
        i_rd_cyc = 1'b1;
        i_rd_stb = 1'b1;
        i_rd_adr = adr;
        for (k = 0; k < TIMEOUT; k++) begin
            @(posedge i_clk);
            #1;
            if (o_rd_ack) break;
        end
        if (k == TIMEOUT) stop_run($sformatf("read of address %h never acknowledged", adr));
        dat = o_rd_dat;
        @(posedge i_clk);
        #1;
        i_rd_cyc = 1'b0;
        i_rd_stb = 1'b0;
        idle_gap();
    endtask

    task automatic run_test();
        int k;
        bus_write(8'h00, conf);
        bus_write(8'h01, 32'h0);
        // part of the row first, then weights, then the rest
        for (int i = 0; i < split; i++) bus_write(8'h02, {24'h0, in_vals[i]});
        for (int c = 0; c < `PE_COLS; c++) begin
            for (int w = 0; w < nwt; w++) bus_write(8'h10 + c, {24'h0, wt_vals[c][w]});
        end
        for (int i = split; i < nin; i++) bus_write(8'h02, {24'h0, in_vals[i]});
        // poll the result count
        for (k = 0; k < TIMEOUT; k++) begin
            bus_read(8'h00, rd_val);
            if (rd_val == 16'(nres)) break;
        end
        if (k == TIMEOUT) stop_run($sformatf("%s never reached its result count", name));
        for (int r = 0; r < nres; r++) begin
            bus_read(8'(r + 1), rd_val);
            assert (rd_val == exp_vals[r]) else begin
                $display("ERR %s slot %0d expected %h actual %h", name, r, exp_vals[r], rd_val);
                errors++;
                $display("CHECKS FAILED");
                $fatal(1);
            end
        end
        // the run is over, so the count stays put
        bus_read(8'h00, rd_val);
        assert (rd_val == 16'(nres)) else begin
            $display("ERR %s count expected %h actual %h", name, 16'(nres), rd_val);
            errors++;
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        void'($urandom(32'hcc6d976d));
        errors   = 0;
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        i_rd_cyc = 1'b0;
        i_rd_stb = 1'b0;
        i_rd_adr = '0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        fd = $fopen("pe_row_stim.txt", "r");
        if (fd == 0) stop_run("cannot open pe_row_stim.txt");
        // two column-description lines
        code = $fgets(line, fd);
        code = $fgets(line, fd);
        forever begin
            code = $fscanf(fd, "%s", name);
            if (code != 1 || name == "end") break;
            code = $fscanf(fd, "%h %d %d %d %d", conf, split, nin, nwt, nres);
            if (code != 5) stop_run($sformatf("bad header line for %s in stimulus file", name));
            for (int i = 0; i < nin; i++) code = $fscanf(fd, "%h", in_vals[i]);
            for (int c = 0; c < `PE_COLS; c++) begin
                for (int w = 0; w < nwt; w++) code = $fscanf(fd, "%h", wt_vals[c][w]);
            end
            for (int r = 0; r < nres; r++) code = $fscanf(fd, "%h", exp_vals[r]);
            run_test();
        end
        $fclose(fd);

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- pe_row_properties.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module pe_row_properties (
    input logic                             i_clk,
    input logic                             i_rst_n,
    input logic                             i_wb_cyc,
    input logic                             i_wb_stb,
    input logic                             o_wb_ack,
    input logic                             i_rd_cyc,
    input logic                             i_rd_stb,
    input logic                             o_rd_ack,
    input logic [`PE_COLS-1:0]              psum_rdy,
    input logic [`PE_COLS-1:0]              psum_ack,
    input logic [`PE_COLS-1:0][`PSUM_W-1:0] psum_data
);

    // bus acks only inside a cycle
    wb_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> i_wb_cyc && i_wb_stb) else $error("write ack outside cycle");
    rd_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rd_ack |-> i_rd_cyc && i_rd_stb) else $error("read ack outside cycle");

    // quiet during reset
    no_ack_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> !o_wb_ack && !o_rd_ack) else $error("ack during reset");

    // a psum offer is held until taken
    for (genvar c = 0; c < `PE_COLS; c++) begin : g_hold
        psum_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            psum_rdy[c] && !psum_ack[c] |=> psum_rdy[c] && $stable(psum_data[c]))
            else $error("psum offer dropped or changed");
    end

endmodule

bind pe_row_top pe_row_properties u_props (
    .i_clk, .i_rst_n, .i_wb_cyc, .i_wb_stb, .o_wb_ack,
    .i_rd_cyc, .i_rd_stb, .o_rd_ack,
    .psum_rdy, .psum_ack, .psum_data
);

//--- pe_row_top.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module pe_row_top
    import pe_cfg_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // host write port
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [`WB_ADR_W-1:0]  i_wb_adr,
    input  logic [`WB_DAT_W-1:0]  i_wb_dat,
    output logic                  o_wb_ack,
    // host read port
    input  logic                  i_rd_cyc,
    input  logic                  i_rd_stb,
    input  logic [`WB_ADR_W-1:0]  i_rd_adr,
    output logic [`PSUM_W-1:0]    o_rd_dat,
    output logic                  o_rd_ack
);

    logic                             start;
    logic [CFG_R_W-1:0]               cfg_r;
    logic [CFG_U_W-1:0]               cfg_u;
    logic [CFG_TW_W-1:0]              cfg_tw;
    logic [CFG_PCH_W-1:0]             cfg_pch;
    psum_mode_e                       cfg_mode;
    logic [`PE_COLS-1:0]              in_rdy;
    logic [`PE_COLS-1:0]              in_ack;
    logic [`DATA_W-1:0]               in_data;
    logic [`PE_COLS-1:0]              wt_rdy;
    logic [`PE_COLS-1:0]              wt_ack;
    logic [`DATA_W-1:0]               wt_data;
    logic [`PE_COLS-1:0]              psum_rdy;
    logic [`PE_COLS-1:0]              psum_ack;
    logic [`PE_COLS-1:0][`PSUM_W-1:0] psum_data;

    pe_feeder u_feeder (
        .i_clk, .i_rst_n,
        .i_wb_cyc, .i_wb_stb, .i_wb_we, .i_wb_adr, .i_wb_dat, .o_wb_ack,
        .o_start    (start),
        .o_cfg_r    (cfg_r),
        .o_cfg_u    (cfg_u),
        .o_cfg_tw   (cfg_tw),
        .o_cfg_pch  (cfg_pch),
        .o_cfg_mode (cfg_mode),
        .o_in_rdy   (in_rdy),
        .o_in_data  (in_data),
        .i_in_ack   (in_ack),
        .o_wt_rdy   (wt_rdy),
        .o_wt_data  (wt_data),
        .i_wt_ack   (wt_ack)
    );

    // identical columns, each with its own weight row
    for (genvar c = 0; c < `PE_COLS; c++) begin : g_col
        pe_col u_col (
            .i_clk, .i_rst_n,
            .i_start     (start),
            .i_cfg_r     (cfg_r),
            .i_cfg_u     (cfg_u),
            .i_cfg_tw    (cfg_tw),
            .i_cfg_pch   (cfg_pch),
            .i_cfg_mode  (cfg_mode),
            .i_in_rdy    (in_rdy[c]),
            .i_in_data   (in_data),
            .o_in_ack    (in_ack[c]),
            .i_wt_rdy    (wt_rdy[c]),
            .i_wt_data   (wt_data),
            .o_wt_ack    (wt_ack[c]),
            .o_psum_rdy  (psum_rdy[c]),
            .o_psum_data (psum_data[c]),
            .i_psum_ack  (psum_ack[c])
        );
    end

    psum_drain u_drain (
        .i_clk, .i_rst_n,
        .i_start     (start),
        .i_psum_rdy  (psum_rdy),
        .i_psum_data (psum_data),
        .o_psum_ack  (psum_ack),
        .i_rd_cyc, .i_rd_stb, .i_rd_adr, .o_rd_dat, .o_rd_ack
    );

endmodule

//--- psum_drain.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module psum_drain
    import pe_bus_pkg::*;
(
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_start,
    input  logic [`PE_COLS-1:0]              i_psum_rdy,
    input  logic [`PE_COLS-1:0][`PSUM_W-1:0] i_psum_data,
    output logic [`PE_COLS-1:0]              o_psum_ack,
    input  logic                             i_rd_cyc,
    input  logic                             i_rd_stb,
    input  logic [`WB_ADR_W-1:0]             i_rd_adr,
    output logic [`PSUM_W-1:0]               o_rd_dat,
    output logic                             o_rd_ack
);

    localparam int CSEL_W = $clog2(`PE_COLS);

    logic [CSEL_W-1:0]    ptr_c;
    logic [`RES_AW-1:0]   ptr_t;
    logic [`RES_AW:0]     count;
    logic                 take;
    logic [`WB_ADR_W-1:0] rd_slot;
    logic [`PSUM_W-1:0]   res_mem [`RES_DEPTH];

    // only the column under the pointer is acked
    assign take = i_psum_rdy[ptr_c];

    always_comb begin
        o_psum_ack        = '0;
        o_psum_ack[ptr_c] = take;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ptr_c <= '0;
            ptr_t <= '0;
            count <= '0;
        end else if (i_start) begin
            ptr_c <= '0;
            ptr_t <= '0;
            count <= '0;
        end else if (take) begin
            ptr_c <= ptr_c + 1'b1;
            if (ptr_c == CSEL_W'(`PE_COLS - 1)) ptr_t <= ptr_t + 1'b1;
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take && !i_start) res_mem[res_slot(ptr_t, ptr_c)] <= i_psum_data[ptr_c];
    end

    //============================================================
    // host read port
    //============================================================
    assign rd_slot = i_rd_adr - RES_BASE_ADR;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_ack <= 1'b0;
        end else begin
            o_rd_ack <= i_rd_cyc && i_rd_stb && !o_rd_ack;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd_adr == RES_COUNT_ADR) begin
            o_rd_dat <= {{(`PSUM_W-`RES_AW-1){1'b0}}, count};
        end else begin
            o_rd_dat <= res_mem[rd_slot[`RES_AW-1:0]];
        end
    end

endmodule

//--- pe_feeder.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module pe_feeder
    import pe_cfg_pkg::*;
    import pe_bus_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [`WB_ADR_W-1:0]  i_wb_adr,
    input  logic [`WB_DAT_W-1:0]  i_wb_dat,
    output logic                  o_wb_ack,
    output logic                  o_start,
    output logic [CFG_R_W-1:0]    o_cfg_r,
    output logic [CFG_U_W-1:0]    o_cfg_u,
    output logic [CFG_TW_W-1:0]   o_cfg_tw,
    output logic [CFG_PCH_W-1:0]  o_cfg_pch,
    output psum_mode_e            o_cfg_mode,
    output logic [`PE_COLS-1:0]   o_in_rdy,
    output logic [`DATA_W-1:0]    o_in_data,
    input  logic [`PE_COLS-1:0]   i_in_ack,
    output logic [`PE_COLS-1:0]   o_wt_rdy,
    output logic [`DATA_W-1:0]    o_wt_data,
    input  logic [`PE_COLS-1:0]   i_wt_ack
);

    localparam int CSEL_W  = $clog2(`PE_COLS);
    localparam int FIELD_W = 4;
    localparam logic [`WB_ADR_W-1:0] WT_BASE = REG_WEIGHT;

    logic                req;
    logic                is_conf;
    logic                is_start;
    logic                is_input;
    logic                is_weight;
    logic                in_busy;
    logic [`PE_COLS-1:0] in_done;
    logic [`PE_COLS-1:0] in_done_nxt;
    logic [`PE_COLS-1:0] wt_sel;

    // a new request only when no stream transfer is in flight
    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack && !in_busy && !(|o_wt_rdy);

    assign is_conf   = i_wb_adr == REG_CONF;
    assign is_start  = i_wb_adr == REG_START;
    assign is_input  = i_wb_adr == REG_INPUT;
    assign is_weight = i_wb_adr[`WB_ADR_W-1:FIELD_W] == WT_BASE[`WB_ADR_W-1:FIELD_W]
                       && i_wb_adr[FIELD_W-1:0] < FIELD_W'(`PE_COLS);

    always_comb begin
        wt_sel = '0;
        wt_sel[i_wb_adr[CSEL_W-1:0]] = 1'b1;
    end

    // broadcast item stays offered to the columns that have not taken it
    assign o_in_rdy    = {`PE_COLS{in_busy}} & ~in_done;
    assign in_done_nxt = in_done | (o_in_rdy & i_in_ack);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack   <= 1'b0;
            o_start    <= 1'b0;
            in_busy    <= 1'b0;
            in_done    <= '0;
            o_wt_rdy   <= '0;
            o_cfg_r    <= '0;
            o_cfg_u    <= '0;
            o_cfg_tw   <= '0;
            o_cfg_pch  <= '0;
            o_cfg_mode <= D16;
        end else begin
            o_wb_ack <= 1'b0;
            o_start  <= 1'b0;
            if (req) begin
                if (i_wb_we && is_input) begin
                    in_busy <= 1'b1;
                end else if (i_wb_we && is_weight) begin
                    o_wt_rdy <= wt_sel;
                end else begin
                    o_wb_ack <= 1'b1;
                    if (i_wb_we && is_conf) begin
                        o_cfg_r    <= i_wb_dat[CONF_R_LSB +: CFG_R_W];
                        o_cfg_u    <= i_wb_dat[CONF_U_LSB +: CFG_U_W];
                        o_cfg_tw   <= i_wb_dat[CONF_TW_LSB +: CFG_TW_W];
                        o_cfg_pch  <= i_wb_dat[CONF_PCH_LSB +: CFG_PCH_W];
                        o_cfg_mode <= psum_mode_e'(i_wb_dat[CONF_MODE_BIT]);
                    end
                    if (i_wb_we && is_start) o_start <= 1'b1;
                end
            end
            if (in_busy) begin
                if (&in_done_nxt) begin
                    in_busy  <= 1'b0;
                    in_done  <= '0;
                    o_wb_ack <= 1'b1;
                end else begin
                    in_done <= in_done_nxt;
                end
            end
            if (|(o_wt_rdy & i_wt_ack)) begin
                o_wt_rdy <= '0;
                o_wb_ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req && is_input) o_in_data <= i_wb_dat[`DATA_W-1:0];
        if (req && is_weight) o_wt_data <= i_wb_dat[`DATA_W-1:0];
    end

endmodule

//--- pe_col.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module pe_col
    import pe_cfg_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic [CFG_R_W-1:0]    i_cfg_r,
    input  logic [CFG_U_W-1:0]    i_cfg_u,
    input  logic [CFG_TW_W-1:0]   i_cfg_tw,
    input  logic [CFG_PCH_W-1:0]  i_cfg_pch,
    input  psum_mode_e            i_cfg_mode,
    input  logic                  i_in_rdy,
    input  logic [`DATA_W-1:0]    i_in_data,
    output logic                  o_in_ack,
    input  logic                  i_wt_rdy,
    input  logic [`DATA_W-1:0]    i_wt_data,
    output logic                  o_wt_ack,
    output logic                  o_psum_rdy,
    output logic [`PSUM_W-1:0]    o_psum_data,
    input  logic                  i_psum_ack
);

    logic signed [`DATA_W-1:0] ipad [`IPAD_DEPTH];
    logic signed [`DATA_W-1:0] wpad [`WPAD_DEPTH];

    logic                      mac_en;
    logic                      first_step;
    logic                      chan;
    logic [`IPAD_AW-1:0]       ipad_raddr;
    logic [`IPAD_AW-1:0]       ipad_waddr;
    logic [`WPAD_AW-1:0]       wpad_raddr;
    logic [`WPAD_AW-1:0]       wpad_waddr;
    logic signed [`PSUM_W-1:0] prod;
    psum_word_u                acc;
    psum_word_u                acc_nxt;

    datapath_ctl u_ctl (
        .i_clk, .i_rst_n, .i_start,
        .i_cfg_r, .i_cfg_u, .i_cfg_tw, .i_cfg_pch,
        .i_in_rdy, .o_in_ack,
        .i_wt_rdy, .o_wt_ack,
        .o_main_rdy   (o_psum_rdy),
        .i_main_ack   (i_psum_ack),
        .o_mac_en     (mac_en),
        .o_ipad_raddr (ipad_raddr),
        .o_wpad_raddr (wpad_raddr),
        .o_ipad_waddr (ipad_waddr),
        .o_wpad_waddr (wpad_waddr),
        .o_first_step (first_step),
        .o_chan       (chan)
    );

    // scratch pads, written on accepted transfers
    always_ff @(posedge i_clk) begin
        if (i_in_rdy && o_in_ack) ipad[ipad_waddr] <= i_in_data;
        if (i_wt_rdy && o_wt_ack) wpad[wpad_waddr] <= i_wt_data;
    end

    assign prod = ipad[ipad_raddr] * wpad[wpad_raddr];

    always_comb begin
        if (first_step) begin
            acc_nxt = '0;
        end else begin
            acc_nxt = acc;
        end
        if (i_cfg_mode == D16) begin
            acc_nxt.sum = acc_nxt.sum + prod;
        end else begin
            // per-channel lane, low byte of the product, wraps
            acc_nxt.lane[chan] = acc_nxt.lane[chan] + prod[`PSUM_W/2-1:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (mac_en) acc <= acc_nxt;
    end

    assign o_psum_data = acc;

endmodule

//--- datapath_ctl.sv
`timescale 1ns/1ps
`include "pe_row_defines.svh"

module datapath_ctl
    import pe_cfg_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic [CFG_R_W-1:0]    i_cfg_r,
    input  logic [CFG_U_W-1:0]    i_cfg_u,
    input  logic [CFG_TW_W-1:0]   i_cfg_tw,
    input  logic [CFG_PCH_W-1:0]  i_cfg_pch,
    input  logic                  i_in_rdy,
    output logic                  o_in_ack,
    input  logic                  i_wt_rdy,
    output logic                  o_wt_ack,
    output logic                  o_main_rdy,
    input  logic                  i_main_ack,
    output logic                  o_mac_en,
    output logic [`IPAD_AW-1:0]   o_ipad_raddr,
    output logic [`WPAD_AW-1:0]   o_wpad_raddr,
    output logic [`IPAD_AW-1:0]   o_ipad_waddr,
    output logic [`WPAD_AW-1:0]   o_wpad_waddr,
    output logic                  o_first_step,
    output logic                  o_chan
);

    localparam int IDX_W = 7;
    localparam int CNT_W = 8;
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_INIT = 2'd1;
    localparam logic [1:0] S_WORK = 2'd2;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       ce;
    logic       clr;

    // input loop: channel, pixel
    logic [1:0][IDX_W-1:0] in_size;
    logic [1:0][IDX_W-1:0] in_idx;
    logic                  in_all_end;
    // weight loop: channel, tap
    logic [1:0][IDX_W-1:0] wt_size;
    logic [1:0][IDX_W-1:0] wt_idx;
    logic                  wt_all_end;
    // output loop: channel, tap, t
    logic [2:0][IDX_W-1:0] out_size;
    logic [2:0][IDX_W-1:0] out_idx;
    logic [2:0]            out_end;
    logic                  out_all_end;

    logic [IDX_W-1:0] row_tile;
    logic             in_inc;
    logic             wt_inc;
    logic             in_done;
    logic             wt_done;
    logic             out_done;
    logic [CNT_W-1:0] in_cnt;
    logic [CNT_W-1:0] wt_cnt;
    logic [CNT_W-1:0] in_need;
    logic [CNT_W-1:0] wt_need;
    logic             in_avail;
    logic             wt_avail;

    assign ce  = state == S_WORK;
    assign clr = state == S_INIT;

    //============================================================
    // loop sizes and counters
    //============================================================
    assign row_tile = (IDX_W'(i_cfg_tw) - 1'b1) * IDX_W'(i_cfg_u) + IDX_W'(i_cfg_r);
    assign in_size  = {row_tile, IDX_W'(i_cfg_pch)};
    assign wt_size  = {IDX_W'(i_cfg_r), IDX_W'(i_cfg_pch)};
    assign out_size = {IDX_W'(i_cfg_tw), IDX_W'(i_cfg_r), IDX_W'(i_cfg_pch)};

    assign in_inc = i_in_rdy && o_in_ack;
    assign wt_inc = i_wt_rdy && o_wt_ack;

    loop_counter #(.NDEPTH(2), .IDX_W(IDX_W)) u_in_lp (
        .i_clk, .i_rst_n, .i_clear(clr), .i_inc(in_inc), .i_size(in_size),
        .o_idx(in_idx), .o_end(), .o_all_end(in_all_end)
    );

    loop_counter #(.NDEPTH(2), .IDX_W(IDX_W)) u_wt_lp (
        .i_clk, .i_rst_n, .i_clear(clr), .i_inc(wt_inc), .i_size(wt_size),
        .o_idx(wt_idx), .o_end(), .o_all_end(wt_all_end)
    );

    loop_counter #(.NDEPTH(3), .IDX_W(IDX_W)) u_out_lp (
        .i_clk, .i_rst_n, .i_clear(clr), .i_inc(o_mac_en), .i_size(out_size),
        .o_idx(out_idx), .o_end(out_end), .o_all_end(out_all_end)
    );

    //============================================================
    // catch-up between arrivals and the MAC
    //============================================================
    // items written so far, and the item the current step needs
    assign in_cnt  = CNT_W'(in_idx[1]) * CNT_W'(i_cfg_pch) + CNT_W'(in_idx[0]);
    assign wt_cnt  = CNT_W'(wt_idx[1]) * CNT_W'(i_cfg_pch) + CNT_W'(wt_idx[0]);
    assign in_need = (CNT_W'(out_idx[2]) * CNT_W'(i_cfg_u) + CNT_W'(out_idx[1]))
                     * CNT_W'(i_cfg_pch) + CNT_W'(out_idx[0]);
    assign wt_need = CNT_W'(out_idx[1]) * CNT_W'(i_cfg_pch) + CNT_W'(out_idx[0]);

    assign in_avail = in_done || (in_need < in_cnt);
    assign wt_avail = wt_done || (wt_need < wt_cnt);

    assign o_in_ack = ce && !in_done;
    assign o_wt_ack = ce && !wt_done;

    // a pending psum holds the output loop
    assign o_mac_en     = ce && !out_done && !o_main_rdy && in_avail && wt_avail;
    assign o_first_step = o_mac_en && out_idx[0] == '0 && out_idx[1] == '0;
    assign o_chan       = out_idx[0][0];

    assign o_ipad_waddr = in_cnt[`IPAD_AW-1:0];
    assign o_wpad_waddr = wt_cnt[`WPAD_AW-1:0];
    assign o_ipad_raddr = in_need[`IPAD_AW-1:0];
    assign o_wpad_raddr = wt_need[`WPAD_AW-1:0];

    //============================================================
    // main FSM
    //============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: if (i_start) state_nxt = S_INIT;
            S_INIT: state_nxt = S_WORK;
            S_WORK: if (out_done && o_main_rdy && i_main_ack) state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= S_IDLE;
            in_done    <= 1'b0;
            wt_done    <= 1'b0;
            out_done   <= 1'b0;
            o_main_rdy <= 1'b0;
        end else begin
            state <= state_nxt;
            if (clr) begin
                in_done    <= 1'b0;
                wt_done    <= 1'b0;
                out_done   <= 1'b0;
                o_main_rdy <= 1'b0;
            end else begin
                if (in_inc && in_all_end) in_done <= 1'b1;
                if (wt_inc && wt_all_end) wt_done <= 1'b1;
                if (o_mac_en && out_all_end) out_done <= 1'b1;
                // last tap and channel of this t, offer the psum next cycle
                if (o_mac_en && out_end[0] && out_end[1]) begin
                    o_main_rdy <= 1'b1;
                end else if (o_main_rdy && i_main_ack) begin
                    o_main_rdy <= 1'b0;
                end
            end
        end
    end

endmodule

//--- loop_counter.sv
`timescale 1ns/1ps

module loop_counter #(
    parameter int NDEPTH = 2,
    parameter int IDX_W  = 7
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_clear,
    input  logic                         i_inc,
    input  logic [NDEPTH-1:0][IDX_W-1:0] i_size,
    output logic [NDEPTH-1:0][IDX_W-1:0] o_idx,
    output logic [NDEPTH-1:0]            o_end,
    output logic                         o_all_end
);

    // carry[k] is set when every level below k sits at its last value
    logic [NDEPTH:0] carry;

    always_comb begin
        carry[0] = 1'b1;
        for (int k = 0; k < NDEPTH; k++) begin
            o_end[k]   = o_idx[k] == i_size[k] - 1'b1;
            carry[k+1] = carry[k] && o_end[k];
        end
    end

    assign o_all_end = carry[NDEPTH];

    // odometer, innermost level first, holds at the final count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_idx <= '0;
        end else if (i_clear) begin
            o_idx <= '0;
        end else if (i_inc && !o_all_end) begin
            for (int k = 0; k < NDEPTH; k++) begin
                if (carry[k]) begin
                    o_idx[k] <= o_end[k] ? '0 : o_idx[k] + 1'b1;
                end
            end
        end
    end

endmodule

//--- pe_bus_pkg.sv
`include "pe_row_defines.svh"

package pe_bus_pkg;

    // host write map, WEIGHT is a base plus the column number
    typedef enum logic [`WB_ADR_W-1:0] {
        REG_CONF   = 'h00,
        REG_START  = 'h01,
        REG_INPUT  = 'h02,
        REG_WEIGHT = 'h10
    } wb_reg_e;

    // result port layout
    localparam logic [`WB_ADR_W-1:0] RES_COUNT_ADR = 'h00;
    localparam logic [`WB_ADR_W-1:0] RES_BASE_ADR  = 'h01;

    // memory slot of output t of column c, i.e. t * PE_COLS + c
    function automatic logic [`RES_AW-1:0] res_slot(
        input logic [`RES_AW-1:0]          t,
        input logic [$clog2(`PE_COLS)-1:0] c
    );
        return {t[`RES_AW-$clog2(`PE_COLS)-1:0], c};
    endfunction

endpackage

//--- pe_cfg_pkg.sv
`include "pe_row_defines.svh"

package pe_cfg_pkg;

    // config field widths
    localparam int CFG_R_W   = 4;
    localparam int CFG_U_W   = 4;
    localparam int CFG_TW_W  = 6;
    localparam int CFG_PCH_W = 2;

    // field positions in the CONF data word
    localparam int CONF_R_LSB    = 0;
    localparam int CONF_U_LSB    = 4;
    localparam int CONF_TW_LSB   = 8;
    localparam int CONF_PCH_LSB  = 14;
    localparam int CONF_MODE_BIT = 16;

    typedef enum logic {
        D16 = 1'b0,
        D8  = 1'b1
    } psum_mode_e;

    // one signed sum, or two wrapping lanes (lane 0 is channel 0)
    typedef union packed {
        logic signed [`PSUM_W-1:0]     sum;
        logic [1:0][`PSUM_W/2-1:0]     lane;
    } psum_word_u;

endpackage

//--- pe_row_defines.svh
`ifndef PE_ROW_DEFINES_SVH
`define PE_ROW_DEFINES_SVH

// row size and scratch-pad depths
`define PE_COLS     4
`define IPAD_DEPTH  32
`define WPAD_DEPTH  16
`define RES_DEPTH   64

// address widths of the pads and the result memory
`define IPAD_AW     5
`define WPAD_AW     4
`define RES_AW      6

// data widths
`define DATA_W      8
`define PSUM_W      16
`define WB_ADR_W    8
`define WB_DAT_W    32

`endif
